//--- src/board_pkg.sv
package board_pkg;

    // ----------------------------------------
    // Clock rates

    localparam int clk_mhz   = 50;                   // Board oscillator
    localparam int vga_clock = 25;                   // Pixel clock
    localparam int pixel_div = clk_mhz / vga_clock;  // System cycles per pixel

    // ----------------------------------------
    // Pin group widths

    localparam int w_key   = 4;   // Active-low push buttons
    localparam int w_sw    = 10;  // Top switch doubles as reset
    localparam int w_led   = 10;
    localparam int w_digit = 6;

    // HEX outputs carry segments a to g only, the board has no dp pin
    localparam int w_hex = 7;

endpackage

//--- src/lab_pkg.sv
package lab_pkg;

    // ----------------------------------------
    // Microphone

    localparam int w_mic = 24;  // INMP441 sample width

    // Serial clock is clk / (2 * sck_half), about 3.1 MHz at 50 MHz
    localparam int sck_half = 8;

    // A full frame is two channels of this many serial clocks
    localparam int slots_per_channel = 32;

    // ----------------------------------------
    // Display scan

    // Bit 7 is segment a, bit 0 is the decimal point h
    localparam int w_seg = 8;

    // One digit step per millisecond at 50 MHz
    localparam int scan_div_default = 50000;

endpackage

//--- src/clock_enable_gen.sv
`timescale 1ns/1ps

module clock_enable_gen
#(
    parameter int divisor = 2
)
(
    input  logic clk,
    input  logic rst,
    output logic enable
);

    // Keep at least one bit so a divisor of one still builds
    localparam int w_cnt = divisor > 1 ? $clog2(divisor) : 1;

    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt    <= '0;
            enable <= 1'b0;
        end
        else if (cnt == w_cnt'(divisor - 1))
        begin
            cnt    <= '0;
            enable <= 1'b1;  // Last count of the period
        end
        else
        begin
            cnt    <= cnt + 1'b1;
            enable <= 1'b0;
        end
    end

endmodule

//--- src/inmp441_mic_i2s_receiver.sv
`timescale 1ns/1ps

module inmp441_mic_i2s_receiver
(
    input  logic                          clk,
    input  logic                          rst,
    output logic                          sck,
    output logic                          ws,
    output logic                          lr,
    input  logic                          sd,
    output logic [lab_pkg::w_mic - 1:0]   sample,
    output logic                          sample_valid
);

    import lab_pkg::*;

    localparam int w_cyc  = $clog2(sck_half);
    localparam int n_slot = 2 * slots_per_channel;  // Left plus right
    localparam int w_slot = $clog2(n_slot);

    logic [w_cyc - 1:0]  cyc_cnt;
    logic [w_slot - 1:0] slot;
    logic [w_slot - 1:0] slot_next;
    logic                toggle;
    logic                sck_rise;
    logic                sck_fall;
    logic                left_bit;
    logic                capture_done;
    logic [w_mic - 1:0]  shift;

    // ----------------------------------------
    // Serial clock and word select

    assign toggle   = cyc_cnt == w_cyc'(sck_half - 1);
    assign sck_rise = toggle & ~sck;
    assign sck_fall = toggle & sck;

    assign slot_next = (slot == w_slot'(n_slot - 1)) ? '0 : slot + 1'b1;

    // Slot 0 holds the I2S one-bit delay, data starts in slot 1
    assign left_bit = sck_rise && !ws && slot != '0 && slot <= w_slot'(w_mic);

    assign lr = 1'b0;  // Mic answers in the left channel

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cyc_cnt      <= '0;
            sck          <= 1'b0;
            ws           <= 1'b0;
            slot         <= '0;
            capture_done <= 1'b0;
            sample_valid <= 1'b0;
        end
        else
        begin
            cyc_cnt <= toggle ? '0 : cyc_cnt + 1'b1;

            if (toggle)
                sck <= ~sck;

            // Slot and channel advance together on the falling edge
            if (sck_fall)
            begin
                slot <= slot_next;
                ws   <= slot_next >= w_slot'(slots_per_channel);
            end

            capture_done <= left_bit && slot == w_slot'(w_mic);
            sample_valid <= capture_done;
        end
    end

    // ----------------------------------------
    // Left sample capture

    always_ff @(posedge clk)
    begin
        if (left_bit)
            shift <= {shift[w_mic - 2:0], sd};  // MSB arrives first

        if (capture_done)
            sample <= shift;
    end

endmodule

//--- src/hex_scan_display.sv
`timescale 1ns/1ps

module hex_scan_display
(
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            scan_tick,
    input  logic [board_pkg::w_key - 1:0]                   key,
    input  logic [board_pkg::w_sw - 2:0]                    sw,
    input  logic [lab_pkg::w_mic - 1:0]                     sample,
    input  logic                                            sample_valid,
    output logic [board_pkg::w_led - board_pkg::w_digit - 1:0] led,
    output logic [lab_pkg::w_seg - 1:0]                     abcdefgh,
    output logic [board_pkg::w_digit - 1:0]                 digit
);

    import board_pkg::*;
    import lab_pkg::*;

    localparam int w_idx = $clog2(w_digit);

    logic [w_mic - 1:0] mic_word;
    logic [w_mic - 1:0] word;
    logic               show_mic;
    logic               show_mic_q;
    logic [w_idx - 1:0] idx;
    logic [w_idx - 1:0] idx_next;
    logic [3:0]         nibble;
    logic [w_seg - 2:0] segs;      // a to g
    logic               dp_bit;

    always_ff @(posedge clk)
    begin
        if (sample_valid)
            mic_word <= sample;
    end

    // ----------------------------------------
    // Source select and digit step

    assign show_mic = key[0];
    assign word     = show_mic ? mic_word : w_mic'(sw);

    always_comb
    begin
        idx_next = idx;
        if (scan_tick)
            idx_next = (idx == w_idx'(w_digit - 1)) ? '0 : idx + 1'b1;
    end

    assign nibble = word[4 * idx_next +: 4];
    assign dp_bit = show_mic && idx_next == w_idx'(w_digit - 1);  // Marks mic mode

    // ----------------------------------------
    // Hex glyphs

    always_comb
    begin
        case (nibble)
            4'h0: segs = 7'b1111110;
            4'h1: segs = 7'b0110000;
            4'h2: segs = 7'b1101101;
            4'h3: segs = 7'b1111001;
            4'h4: segs = 7'b0110011;
            4'h5: segs = 7'b1011011;
            4'h6: segs = 7'b1011111;
            4'h7: segs = 7'b1110000;
            4'h8: segs = 7'b1111111;
            4'h9: segs = 7'b1111011;
            4'ha: segs = 7'b1110111;
            4'hb: segs = 7'b0011111;  // Lower case b
            4'hc: segs = 7'b1001110;
            4'hd: segs = 7'b0111101;  // Lower case d
            4'he: segs = 7'b1001111;
            default: segs = 7'b1000111;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            idx        <= '0;
            digit      <= w_digit'(1);
            abcdefgh   <= '0;      // Blank until the first step
            show_mic_q <= 1'b0;
            led        <= '0;
        end
        else
        begin
            idx        <= idx_next;
            digit      <= w_digit'(1) << idx_next;
            show_mic_q <= show_mic;
            led        <= key;

            // Refresh on a step, or at once when the source flips
            if (scan_tick || show_mic != show_mic_q)
                abcdefgh <= {segs, dp_bit};
        end
    end

endmodule

//--- src/static_hex_latch.sv
`timescale 1ns/1ps

module static_hex_latch
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic [lab_pkg::w_seg - 1:0]      abcdefgh,
    input  logic [board_pkg::w_digit - 1:0]  digit,
    output logic [board_pkg::w_hex - 1:0]    hex0,
    output logic [board_pkg::w_hex - 1:0]    hex1,
    output logic [board_pkg::w_hex - 1:0]    hex2,
    output logic [board_pkg::w_hex - 1:0]    hex3,
    output logic [board_pkg::w_hex - 1:0]    hex4,
    output logic [board_pkg::w_hex - 1:0]    hex5,
    output logic [board_pkg::w_digit - 1:0]  dp
);

    import board_pkg::*;
    import lab_pkg::*;

    logic [w_seg - 1:0] hgfedcba;
    logic [w_hex - 1:0] hex_q [w_digit];

    // Board HEX pins put segment a at bit 0
    always_comb
    begin
        for (int i = 0; i < w_seg; i++)
        begin
            hgfedcba[i] = abcdefgh[w_seg - 1 - i];
        end
    end

    // ----------------------------------------
    // Sticky digit registers

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int n = 0; n < w_digit; n++)
            begin
                hex_q[n] <= '1;  // Segments are active low
            end
            dp <= '0;
        end
        else
        begin
            for (int n = 0; n < w_digit; n++)
            begin
                if (digit[n])
                begin
                    hex_q[n] <= ~hgfedcba[w_hex - 1:0];
                    dp[n]    <= hgfedcba[w_hex];  // h sits just above g
                end
            end
        end
    end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];
    assign hex4 = hex_q[4];
    assign hex5 = hex_q[5];

endmodule

//--- src/board_specific_top.sv
`timescale 1ns/1ps

module board_specific_top
#(
    parameter int scan_div = lab_pkg::scan_div_default
)
(
    input  logic                            CLOCK_50,
    input  logic [board_pkg::w_key - 1:0]   KEY,
    input  logic [board_pkg::w_sw - 1:0]    SW,
    output logic [board_pkg::w_led - 1:0]   LEDR,
    output logic [board_pkg::w_hex - 1:0]   HEX0,
    output logic [board_pkg::w_hex - 1:0]   HEX1,
    output logic [board_pkg::w_hex - 1:0]   HEX2,
    output logic [board_pkg::w_hex - 1:0]   HEX3,
    output logic [board_pkg::w_hex - 1:0]   HEX4,
    output logic [board_pkg::w_hex - 1:0]   HEX5,
    output logic                            VGA_CLK,
    output logic                            mic_sck,
    output logic                            mic_ws,
    output logic                            mic_lr,
    input  logic                            mic_sd
);

    import board_pkg::*;
    import lab_pkg::*;

    logic                         clk;
    logic                         rst;
    logic [w_key - 1:0]           key;
    logic [w_sw - 2:0]            sw;
    logic                         scan_tick;
    logic [w_mic - 1:0]           sample;
    logic                         sample_valid;
    logic [w_led - w_digit - 1:0] led;
    logic [w_seg - 1:0]           abcdefgh;
    logic [w_digit - 1:0]         digit;
    logic [w_digit - 1:0]         dp;

    assign clk = CLOCK_50;
    assign rst = SW[w_sw - 1];   // Top switch is the reset
    assign key = ~KEY;           // Pressed reads as one
    assign sw  = SW[w_sw - 2:0];

    // ----------------------------------------
    // Timing strobes

    clock_enable_gen #(.divisor(pixel_div)) pixel_enable
    (
        .clk    (clk),
        .rst    (rst),
        .enable (VGA_CLK)
    );

    clock_enable_gen #(.divisor(scan_div)) scan_enable
    (
        .clk    (clk),
        .rst    (rst),
        .enable (scan_tick)
    );

    // ----------------------------------------
    // Mic, scan, latch

    inmp441_mic_i2s_receiver i_mic
    (
        .clk          (clk),
        .rst          (rst),
        .sck          (mic_sck),
        .ws           (mic_ws),
        .lr           (mic_lr),
        .sd           (mic_sd),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    hex_scan_display i_display
    (
        .clk          (clk),
        .rst          (rst),
        .scan_tick    (scan_tick),
        .key          (key),
        .sw           (sw),
        .sample       (sample),
        .sample_valid (sample_valid),
        .led          (led),
        .abcdefgh     (abcdefgh),
        .digit        (digit)
    );

    static_hex_latch i_latch
    (
        .clk      (clk),
        .rst      (rst),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .hex0     (HEX0),
        .hex1     (HEX1),
        .hex2     (HEX2),
        .hex3     (HEX3),
        .hex4     (HEX4),
        .hex5     (HEX5),
        .dp       (dp)
    );

    assign LEDR = {dp, led};  // Upper six LEDs stand in for decimal points

endmodule

//--- dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
#(
    parameter int period_ns = 40
)
(
    output logic clk
);

    initial clk = 1'b0;

    always #(period_ns / 2) clk = ~clk;

endmodule

//--- dv/board_specific_top_chk.sv
`timescale 1ns/1ps

module board_specific_top_chk
(
    input logic       CLOCK_50,
    input logic [9:0] SW,
    input logic [9:0] LEDR,
    input logic       VGA_CLK,
    input logic       mic_sck,
    input logic       mic_ws
);

    // ----------------------------------------
    // Pixel strobe and I2S framing

    assert property (@(posedge CLOCK_50) disable iff (SW[9]) VGA_CLK |=> !VGA_CLK)
        else $error("VGA_CLK high on two cycles in a row");

    assert property (@(posedge CLOCK_50) disable iff (SW[9]) $changed(mic_ws) |-> !mic_sck)
        else $error("mic_ws moved while mic_sck high");

    assert property (@(posedge CLOCK_50) SW[9] |-> LEDR[9:4] == 6'b0)
        else $error("Decimal points lit during reset");

endmodule

bind board_specific_top board_specific_top_chk chk
(
    .CLOCK_50 (CLOCK_50),
    .SW       (SW),
    .LEDR     (LEDR),
    .VGA_CLK  (VGA_CLK),
    .mic_sck  (mic_sck),
    .mic_ws   (mic_ws)
);

//--- dv/board_specific_top_tb.sv
`timescale 1ns/1ps

module board_specific_top_tb;

    logic        clk;
    logic [3:0]  KEY;
    logic [9:0]  SW;
    logic [9:0]  LEDR;
    logic [6:0]  HEX0, HEX1, HEX2, HEX3, HEX4, HEX5;
    logic        VGA_CLK, mic_sck, mic_ws, mic_lr, mic_sd;
    logic [31:0] rng;
    logic [31:0] mic_rng;
    logic [23:0] left_word;
    int          bit_cnt;
    logic        ws_prev;
    int          errors;

    tb_clock #(.period_ns(40)) i_clock (.clk(clk));

    board_specific_top #(.scan_div(8)) uut
    (
        .CLOCK_50 (clk),
        .KEY      (KEY),
        .SW       (SW),
        .LEDR     (LEDR),
        .HEX0     (HEX0),
        .HEX1     (HEX1),
        .HEX2     (HEX2),
        .HEX3     (HEX3),
        .HEX4     (HEX4),
        .HEX5     (HEX5),
        .VGA_CLK  (VGA_CLK),
        .mic_sck  (mic_sck),
        .mic_ws   (mic_ws),
        .mic_lr   (mic_lr),
        .mic_sd   (mic_sd)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ----------------------------------------
    // I2S microphone model, new bit on each falling serial clock

    always @(negedge mic_sck)
    begin
        @(negedge clk);                  // Word select has settled by now
        if (SW[9] || mic_ws != ws_prev)
            bit_cnt = 0;                 // Slot 0 after a channel change
        else
            bit_cnt = bit_cnt + 1;
        ws_prev = mic_ws;
        mic_rng = xorshift(mic_rng);
        if (!mic_ws && bit_cnt >= 1 && bit_cnt <= 24)
            mic_sd <= left_word[24 - bit_cnt];
        else
            mic_sd <= mic_rng[0];        // Right channel noise
    end

    // Segment a at bit 0, active high
    function automatic logic [6:0] glyph(input logic [3:0] n);
        case (n)
            4'h0: return 7'h3f;
            4'h1: return 7'h06;
            4'h2: return 7'h5b;
            4'h3: return 7'h4f;
            4'h4: return 7'h66;
            4'h5: return 7'h6d;
            4'h6: return 7'h7d;
            4'h7: return 7'h07;
            4'h8: return 7'h7f;
            4'h9: return 7'h6f;
            4'ha: return 7'h77;
            4'hb: return 7'h7c;
            4'hc: return 7'h39;
            4'hd: return 7'h5e;
            4'he: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    function automatic logic [6:0] hex_out(input int n);
        case (n)
            0: return HEX0;
            1: return HEX1;
            2: return HEX2;
            3: return HEX3;
            4: return HEX4;
            default: return HEX5;
        endcase
    endfunction

    function automatic bit shows(input logic [23:0] word, input logic mic);
        bit ok;
        ok = (LEDR[9] == mic) && (LEDR[8:4] == 5'b0);
        for (int n = 0; n < 6; n++)
            if (hex_out(n) !== ~glyph(word[4 * n +: 4]))
                ok = 0;
        return ok;
    endfunction

    // Poll the display, then report each wrong output
    task automatic wait_display(input logic [23:0] word, input logic mic, input int limit);
        bit ok;
        ok = 0;
        for (int i = 0; i < limit && !ok; i++)
        begin
            @(negedge clk);
            ok = shows(word, mic);
        end
        if (!ok)
        begin
            errors++;
            $display("Display did not settle on %h within %0d cycles", word, limit);
        end
        for (int n = 0; n < 6; n++)
            if (hex_out(n) !== ~glyph(word[4 * n +: 4]))
                $display("Fail %0t HEX%0d got %b expected %b", $time, n, hex_out(n),
                         ~glyph(word[4 * n +: 4]));
        if (LEDR[9:4] !== {mic, 5'b0})
            $display("Fail %0t LEDR[9:4] got %b expected %b", $time, LEDR[9:4], {mic, 5'b0});
    endtask

    task automatic wait_frames(input int frames);
        int seen;
        logic last;
        seen = 0;
        last = mic_ws;
        for (int i = 0; i < 1100 * (frames + 1) && seen < frames; i++)
        begin
            @(posedge clk);
            if (mic_ws && !last)
                seen++;
            last = mic_ws;
        end
        if (seen < frames)
        begin
            errors++;
            $display("Word select stopped before %0d frames passed", frames);
        end
    endtask

    // ----------------------------------------
    // Directed tests

    task automatic reset_state();
        @(posedge clk);
        SW <= 10'h200;
        for (int i = 0; i < 5; i++)
        begin
            @(negedge clk);
            if ({VGA_CLK, mic_sck, mic_ws, mic_lr} !== 4'b0000)
            begin
                errors++;
                $display("Fail %0t VGA_CLK/mic_sck/mic_ws/mic_lr got %b expected 0000", $time,
                         {VGA_CLK, mic_sck, mic_ws, mic_lr});
            end
            if ({HEX5, HEX4, HEX3, HEX2, HEX1, HEX0} !== '1 || LEDR[9:4] !== 6'b0)
            begin
                errors++;
                $display("Fail %0t HEX/LEDR[9:4] got %h/%b expected all ones/0", $time,
                         {HEX5, HEX4, HEX3, HEX2, HEX1, HEX0}, LEDR[9:4]);
            end
        end
        @(posedge clk);
        SW <= 10'h000;
        for (int i = 0; i < 6; i++)
        begin
            @(negedge clk);
            if ({HEX5, HEX4, HEX3, HEX2, HEX1, HEX0} !== '1 || LEDR[9:4] !== 6'b0)
            begin
                errors++;
                $display("Fail %0t HEX/LEDR[9:4] got %h/%b expected all ones/0", $time,
                         {HEX5, HEX4, HEX3, HEX2, HEX1, HEX0}, LEDR[9:4]);
            end
        end
    endtask

    task automatic pixel_strobe();
        logic exp_vga;
        @(posedge clk);
        SW <= 10'h200;
        @(posedge clk);
        SW <= 10'h000;
        for (int i = 0; i < 42; i++)
        begin
            @(negedge clk);
            exp_vga = (i >= 2) && (i % 2 == 0);  // First strobe two cycles after release
            if (VGA_CLK !== exp_vga)
            begin
                errors++;
                $display("Fail %0t VGA_CLK got %b expected %b", $time, VGA_CLK, exp_vga);
            end
        end
    endtask

    task automatic switch_display();
        logic [3:0] pattern;
        for (int k = 0; k < 5; k++)
        begin
            rng = xorshift(rng);
            pattern = {rng[11:9], 1'b1};
            @(posedge clk);
            SW  <= {1'b0, rng[8:0]};
            KEY <= pattern;
            wait_display({15'b0, rng[8:0]}, 1'b0, 60);
            if (LEDR[3:0] !== ~pattern)
            begin
                errors++;
                $display("Fail %0t LEDR[3:0] got %b expected %b", $time, LEDR[3:0], ~pattern);
            end
        end
    endtask

    task automatic mic_display();
        logic [8:0] sw_val;
        rng = xorshift(rng);
        left_word = rng[23:0];
        sw_val = SW[8:0];
        wait_frames(2);
        @(posedge clk);
        KEY <= 4'b1110;
        wait_display(left_word, 1'b1, 60);
        @(posedge clk);
        KEY <= 4'b1111;
        wait_display({15'b0, sw_val}, 1'b0, 60);
    endtask

    task automatic sample_update();
        @(posedge clk);
        KEY <= 4'b1110;
        wait_display(left_word, 1'b1, 60);
        rng = xorshift(rng);
        left_word = rng[23:0];
        wait_display(left_word, 1'b1, 2 * 1024 + 60);
    endtask

    task automatic midrun_reset();
        @(posedge clk);
        SW  <= 10'h200;
        KEY <= 4'b1111;
        @(negedge clk);
        if ({HEX5, HEX4, HEX3, HEX2, HEX1, HEX0} !== '1)
        begin
            errors++;
            $display("Fail %0t HEX got %h expected all ones", $time,
                     {HEX5, HEX4, HEX3, HEX2, HEX1, HEX0});
        end
    endtask

    initial
    begin
        errors    = 0;
        rng       = 32'h5d0ff612;
        mic_rng   = xorshift(32'h5d0ff612);
        left_word = 24'h0;
        bit_cnt   = 0;
        ws_prev   = 1'b0;
        mic_sd    = 1'b0;
        KEY       = 4'b1111;
        SW        = 10'h200;
        reset_state();
        pixel_strobe();
        switch_display();
        mic_display();
        sample_update();
        midrun_reset();
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

//--- flist.f
src/board_pkg.sv
src/lab_pkg.sv
src/clock_enable_gen.sv
src/inmp441_mic_i2s_receiver.sv
src/hex_scan_display.sv
src/static_hex_latch.sv
src/board_specific_top.sv
dv/tb_clock.sv
dv/board_specific_top_chk.sv
dv/board_specific_top_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f \
    --top-module board_specific_top_tb -o sim

./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with no errors" sim.log; then
    exit 0
fi
exit 1
